// File: dac_nano.f
// package first, then the blocks under the top level
rtl/dac_nano_pkg.sv
rtl/dac_avmm_regs.sv
rtl/dac_gain_in.sv
rtl/dac_update_ctrl.sv
rtl/dac_spi_shifter.sv
rtl/dac_nano_top.sv
// testbench
tests/tb_dac_nano.sv

// File: run_sim.sh
#!/bin/sh
# compiles the dac_nano testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dac_nano \
    -f dac_nano.f \
    -o sim_dac_nano

# a failing run still leaves its log for the search below
sim_status=0
./obj_dir/sim_dac_nano > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, exit status $sim_status"
exit 1

// File: tests/dac_nano_patterns.txt
# op     addr  data      resp  xfer
# rd and rddac compare data and resp, wr wrrnd and gain expect one DAC word when xfer is 1
en       00    00000001  0     0
rd       00    00010d5a  0     0
rd       04    00000004  0     0
rd       0c    00000001  0     0
rd       10    00000000  2     0
rd       fc    00000000  2     0
wr       14    0000ffff  2     0
wrrnd    08    00000000  0     1
rddac    08    00000000  0     0
wr       08    00008abc  0     1
rddac    08    00000000  0     0
wr       00    12345678  0     0
en       00    00000000  0     0
rd       0c    00000000  0     0
wr       08    00001234  0     0
rddac    08    00000000  0     0
gain     00    0000005a  0     1
gain     00    000000a5  0     1
en       00    00000001  0     0
wrrnd    08    00000000  0     1
rddac    08    00000000  0     0

// File: tests/tb_dac_nano.sv
//////////////////////////////
// testbench for dac_nano_top, pattern driven bus and gain
// operations with an SPI word monitor
//////////////////////////////

`timescale 1ns/1ps

module tb_dac_nano;

    localparam int    CLK_PERIOD      = 100;
    localparam int    DRIVE_DLY       = 10;
    localparam int    RESET_CYCLES    = 3;
    localparam int    RSP_TIMEOUT     = 4;
    localparam int    XFER_TIMEOUT    = 60;    // cycles until a word shows up
    localparam int    SETTLE_CYCLES   = 8;     // ack handshake plus strobe
    localparam int    QUIET_CYCLES    = 50;    // longer than one transfer
    localparam int    CYCLES_PER_LINE = 200;
    localparam string PATTERN_FILE    = "tests/dac_nano_patterns.txt";

    logic                    clk_ifc;
    logic                    sreset;
    dac_nano_pkg::avmm_req_t avmm_req;
    logic                    en_avmm_ctrl;
    dac_nano_pkg::gain_t     dac_data_in;
    logic                    dac_data_in_valid_stb;
    dac_nano_pkg::avmm_rsp_t avmm_rsp;
    logic                    dac_data_in_updated_stb;
    logic                    initdone;
    logic                    dac_ssn;
    logic                    dac_sclk;
    logic                    dac_mosi;

    // parsed pattern lines
    logic [63:0]              op_name[$];
    dac_nano_pkg::avmm_addr_t op_addr[$];
    dac_nano_pkg::avmm_data_t op_data[$];
    logic [1:0]               op_resp[$];
    logic                     op_xfer[$];
    int                       pattern_lines = 0;
    logic                     patterns_loaded = 1'b0;

    dac_nano_pkg::dac_word_t  words_seen[$];    // from the SPI pins
    dac_nano_pkg::dac_word_t  shift_word = '0;
    int                       bit_count = 0;
    int                       strobe_count = 0;
    int                       error_count = 0;
    logic [31:0]              lfsr_state = 32'h7065_1b13;
    dac_nano_pkg::avmm_data_t dac_model = {16'd0, dac_nano_pkg::DAC_DEFAULT};

    dac_nano_top i_dut (
        .clk_ifc                 (clk_ifc),
        .sreset                  (sreset),
        .avmm_req                (avmm_req),
        .en_avmm_ctrl            (en_avmm_ctrl),
        .dac_data_in             (dac_data_in),
        .dac_data_in_valid_stb   (dac_data_in_valid_stb),
        .avmm_rsp                (avmm_rsp),
        .dac_data_in_updated_stb (dac_data_in_updated_stb),
        .initdone                (initdone),
        .dac_ssn                 (dac_ssn),
        .dac_sclk                (dac_sclk),
        .dac_mosi                (dac_mosi)
    );

    initial begin
        clk_ifc = 1'b0;
        forever #(CLK_PERIOD / 2) clk_ifc = ~clk_ifc;
    end

    //////////////////////////////
    // monitors

    // DAC samples mosi on sclk falling, msb first
    always @(negedge dac_sclk) begin
        if (dac_ssn == 1'b0) begin
            shift_word = {shift_word[14:0], dac_mosi};
            bit_count  = bit_count + 1;
            if (bit_count == 16) begin
                words_seen.push_back(shift_word);
                bit_count = 0;
            end
        end
    end

    always @(negedge clk_ifc) begin
        if (dac_data_in_updated_stb === 1'b1) begin
            strobe_count = strobe_count + 1;
        end
    end

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
            val        = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    //////////////////////////////
    // failure and compare tasks

    task automatic report_failure(input string what);
        error_count = error_count + 1;
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_data(input string name, input dac_nano_pkg::avmm_data_t got,
                              input dac_nano_pkg::avmm_data_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s is %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s is %b, expected %b",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input dac_nano_pkg::dac_word_t got,
                              input dac_nano_pkg::dac_word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s is %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("FAILED at %0t: %s is %b, expected %b",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("FAILED at %0t: %s is %0d, expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    //////////////////////////////
    // drivers

    task automatic bus_read(input dac_nano_pkg::avmm_addr_t addr,
                            output dac_nano_pkg::avmm_data_t data, output logic [1:0] resp);
        int waited;
        waited = 0;
        @(posedge clk_ifc);
        #DRIVE_DLY;
        avmm_req.read    = 1'b1;
        avmm_req.address = addr;
        @(posedge clk_ifc);
        #DRIVE_DLY;
        avmm_req.read = 1'b0;
        @(negedge clk_ifc);
        while (avmm_rsp.readdatavalid !== 1'b1 && waited < RSP_TIMEOUT) begin
            waited = waited + 1;
            @(negedge clk_ifc);
        end
        if (avmm_rsp.readdatavalid !== 1'b1) begin
            report_failure("the DUT gave no read response");
        end
        data = avmm_rsp.readdata;
        resp = avmm_rsp.response;
    endtask

    task automatic bus_write(input dac_nano_pkg::avmm_addr_t addr,
                             input dac_nano_pkg::avmm_data_t data, output logic [1:0] resp);
        int waited;
        waited = 0;
        @(posedge clk_ifc);
        #DRIVE_DLY;
        avmm_req.write     = 1'b1;
        avmm_req.address   = addr;
        avmm_req.writedata = data;
        @(posedge clk_ifc);
        #DRIVE_DLY;
        avmm_req.write = 1'b0;
        @(negedge clk_ifc);
        while (avmm_rsp.writedone !== 1'b1 && waited < RSP_TIMEOUT) begin
            waited = waited + 1;
            @(negedge clk_ifc);
        end
        if (avmm_rsp.writedone !== 1'b1) begin
            report_failure("the DUT gave no write response");
        end
        resp = avmm_rsp.response;
    endtask

    task automatic gain_strobe(input dac_nano_pkg::gain_t gain);
        @(posedge clk_ifc);
        #DRIVE_DLY;
        dac_data_in           = gain;
        dac_data_in_valid_stb = 1'b1;
        @(posedge clk_ifc);
        #DRIVE_DLY;
        dac_data_in_valid_stb = 1'b0;
    endtask

    task automatic set_enable(input logic level);
        @(posedge clk_ifc);
        #DRIVE_DLY;
        en_avmm_ctrl = level;
        repeat (2) @(posedge clk_ifc);   // mirror register
    endtask

    //////////////////////////////
    // transfer checks

    task automatic expect_transfer(input dac_nano_pkg::dac_word_t exp, input int strobes_before,
                                   input int exp_strobes);
        int                      waited;
        dac_nano_pkg::dac_word_t got;
        waited = 0;
        while (words_seen.size() == 0 && waited < XFER_TIMEOUT) begin
            waited = waited + 1;
            @(negedge clk_ifc);
        end
        if (words_seen.size() == 0) begin
            report_failure("an expected DAC transfer never appeared on the SPI pins");
        end
        got = words_seen.pop_front();
        check_word("dac_mosi word", got, exp);
        repeat (SETTLE_CYCLES) @(negedge clk_ifc);
        check_count("dac_data_in_updated_stb pulses", strobe_count - strobes_before, exp_strobes);
        check_count("extra SPI words", words_seen.size(), 0);
    endtask

    task automatic expect_quiet(input int strobes_before);
        repeat (QUIET_CYCLES) @(negedge clk_ifc);
        check_count("SPI words", words_seen.size(), 0);
        check_count("dac_data_in_updated_stb pulses", strobe_count - strobes_before, 0);
    endtask

    //////////////////////////////
    // pattern file

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [63:0] op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] r;
        logic [31:0] x;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            report_failure("cannot open the pattern file");
        end
        while ($fgets(line, fd) != 0) begin
            pattern_lines = pattern_lines + 1;
            n = $sscanf(line, "%s %h %h %h %h", op, a, d, r, x);
            if (n == 5) begin      // comment lines never parse fully
                op_name.push_back(op);
                op_addr.push_back(a[7:0]);
                op_data.push_back(d);
                op_resp.push_back(r[1:0]);
                op_xfer.push_back(x[0]);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_op(input logic [63:0] op, input dac_nano_pkg::avmm_addr_t addr,
                          input dac_nano_pkg::avmm_data_t data, input logic [1:0] resp,
                          input logic xfer);
        dac_nano_pkg::avmm_data_t rd_val;
        dac_nano_pkg::avmm_data_t wr_val;
        dac_nano_pkg::dac_word_t  exp_word;
        logic [1:0]               got_resp;
        int                       strobes_before;
        strobes_before = strobe_count;
        case (op)
            "en": begin
                set_enable(data[0]);
            end
            "rd": begin
                bus_read(addr, rd_val, got_resp);
                check_data("avmm_rsp.readdata", rd_val, data);
                check_resp("avmm_rsp.response", got_resp, resp);
            end
            "rddac": begin
                bus_read(addr, rd_val, got_resp);
                check_data("avmm_rsp.readdata", rd_val, dac_model);
                check_resp("avmm_rsp.response", got_resp, resp);
            end
            "wr", "wrrnd": begin
                wr_val = (op == "wrrnd") ? rand_bits(32) : data;
                bus_write(addr, wr_val, got_resp);
                check_resp("avmm_rsp.response", got_resp, resp);
                if (xfer) begin
                    dac_model = wr_val;    // accepted write, low half goes out
                    expect_transfer(wr_val[15:0], strobes_before, 0);
                end else begin
                    expect_quiet(strobes_before);
                end
            end
            "gain": begin
                // mode bits, gain, zero padding
                exp_word = {dac_model[15:14], data[7:0], 6'b000000};
                gain_strobe(data[7:0]);
                if (xfer) begin
                    expect_transfer(exp_word, strobes_before, 1);
                end else begin
                    expect_quiet(strobes_before);
                end
            end
            default: begin
                report_failure("the pattern file holds an unknown operation");
            end
        endcase
    endtask

    //////////////////////////////
    // main sequence and watchdog

    initial begin
        avmm_req              = '0;
        en_avmm_ctrl          = 1'b0;
        dac_data_in           = '0;
        dac_data_in_valid_stb = 1'b0;
        sreset                = 1'b1;
        load_patterns();
        patterns_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk_ifc);
        #DRIVE_DLY;
        // idle levels while reset is held
        check_flag("avmm_rsp.waitrequest", avmm_rsp.waitrequest, 1'b1);
        check_flag("dac_ssn", dac_ssn, 1'b1);
        check_flag("dac_sclk", dac_sclk, 1'b1);
        check_flag("initdone", initdone, 1'b0);
        sreset = 1'b0;

        // default word goes out without any request
        expect_transfer(dac_nano_pkg::DAC_DEFAULT, strobe_count, 0);
        check_flag("initdone", initdone, 1'b1);
        check_flag("avmm_rsp.waitrequest", avmm_rsp.waitrequest, 1'b0);

        for (int i = 0; i < op_name.size(); i++) begin
            repeat (rand_bits(3)) @(posedge clk_ifc);   // idle gap
            run_op(op_name[i], op_addr[i], op_data[i], op_resp[i], op_xfer[i]);
        end

        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        wait (patterns_loaded);
        #(CYCLES_PER_LINE * pattern_lines * CLK_PERIOD);
        report_failure("the watchdog expired before the test sequence completed");
    end

endmodule

// File: rtl/dac_nano_top.sv
//////////////////////////////
// dac_nano top level, block instances
//////////////////////////////

`timescale 1ns/1ps

module dac_nano_top (
    input  logic                    clk_ifc,
    input  logic                    sreset,
    input  dac_nano_pkg::avmm_req_t avmm_req,
    input  logic                    en_avmm_ctrl,
    input  dac_nano_pkg::gain_t     dac_data_in,
    input  logic                    dac_data_in_valid_stb,
    output dac_nano_pkg::avmm_rsp_t avmm_rsp,
    output logic                    dac_data_in_updated_stb,
    output logic                    initdone,
    output logic                    dac_ssn,
    output logic                    dac_sclk,
    output logic                    dac_mosi
);

    dac_nano_pkg::dac_src_t   dac_src;
    dac_nano_pkg::gain_pend_t gain_pend;
    dac_nano_pkg::dac_word_t  spi_word;
    logic                     gain_taken;
    logic                     spi_req;
    logic                     spi_ack;

    dac_avmm_regs i_regs (
        .clk_ifc      (clk_ifc),
        .sreset       (sreset),
        .avmm_req     (avmm_req),
        .en_avmm_ctrl (en_avmm_ctrl),
        .avmm_rsp     (avmm_rsp),
        .dac_src      (dac_src)
    );

    dac_gain_in i_gain (
        .clk_ifc               (clk_ifc),
        .sreset                (sreset),
        .dac_data_in           (dac_data_in),
        .dac_data_in_valid_stb (dac_data_in_valid_stb),
        .gain_taken            (gain_taken),
        .gain_pend             (gain_pend)
    );

    dac_update_ctrl i_ctrl (
        .clk_ifc                 (clk_ifc),
        .sreset                  (sreset),
        .dac_src                 (dac_src),
        .gain_pend               (gain_pend),
        .spi_ack                 (spi_ack),
        .gain_taken              (gain_taken),
        .spi_req                 (spi_req),
        .spi_word                (spi_word),
        .dac_data_in_updated_stb (dac_data_in_updated_stb),
        .initdone                (initdone)
    );

    dac_spi_shifter i_spi (
        .clk_ifc  (clk_ifc),
        .sreset   (sreset),
        .spi_req  (spi_req),
        .spi_word (spi_word),
        .spi_ack  (spi_ack),
        .dac_ssn  (dac_ssn),
        .dac_sclk (dac_sclk),
        .dac_mosi (dac_mosi)
    );

endmodule

// File: rtl/dac_spi_shifter.sv
//////////////////////////////
// 16 bit SPI serializer, req/ack handshake
//////////////////////////////

`timescale 1ns/1ps

module dac_spi_shifter (
    input  logic                    clk_ifc,
    input  logic                    sreset,
    input  logic                    spi_req,
    input  dac_nano_pkg::dac_word_t spi_word,
    output logic                    spi_ack,
    output logic                    dac_ssn,
    output logic                    dac_sclk,
    output logic                    dac_mosi
);

    dac_nano_pkg::spi_state_t state;
    dac_nano_pkg::dac_word_t  shreg;
    logic [$clog2($bits(dac_nano_pkg::dac_word_t))-1:0] bit_cnt;
    logic                     phase;   // 0 = sclk high half, 1 = low half

    // msb first, shifts on sclk rising
    assign dac_mosi = shreg[$bits(dac_nano_pkg::dac_word_t)-1];

    always_ff @(posedge clk_ifc) begin
        if (sreset) begin
            state    <= dac_nano_pkg::SPI_IDLE;
            shreg    <= '0;
            bit_cnt  <= '0;
            phase    <= 1'b0;
            spi_ack  <= 1'b0;
            dac_ssn  <= 1'b1;
            dac_sclk <= 1'b1;   // idles high, DAC samples on falling
        end else begin
            case (state)
                dac_nano_pkg::SPI_IDLE: begin
                    if (spi_req) begin
                        shreg   <= spi_word;
                        bit_cnt <= '1;
                        phase   <= 1'b0;
                        dac_ssn <= 1'b0;
                        state   <= dac_nano_pkg::SPI_SHIFT;
                    end
                end
                dac_nano_pkg::SPI_SHIFT: begin
                    phase <= ~phase;
                    if (!phase) begin
                        dac_sclk <= 1'b0;   // DAC samples here
                    end else begin
                        dac_sclk <= 1'b1;
                        shreg    <= shreg << 1;
                        if (bit_cnt == '0) begin
                            dac_ssn <= 1'b1;
                            spi_ack <= 1'b1;
                            state   <= dac_nano_pkg::SPI_ACK;
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                    end
                end
                default: begin      // SPI_ACK, wait for req to drop
                    if (!spi_req) begin
                        spi_ack <= 1'b0;
                        state   <= dac_nano_pkg::SPI_IDLE;
                    end
                end
            endcase
        end
    end

    //////////////////////////////
    // checks

    a_ack_ssn_high: assert property (@(posedge clk_ifc) disable iff (sreset)
        spi_ack |-> dac_ssn);

endmodule

// File: rtl/dac_update_ctrl.sv
//////////////////////////////
// DAC word source select, reset transfer, req/ack sequencing
//////////////////////////////

`timescale 1ns/1ps

module dac_update_ctrl (
    input  logic                     clk_ifc,
    input  logic                     sreset,
    input  dac_nano_pkg::dac_src_t   dac_src,
    input  dac_nano_pkg::gain_pend_t gain_pend,
    input  logic                     spi_ack,
    output logic                     gain_taken,
    output logic                     spi_req,
    output dac_nano_pkg::dac_word_t  spi_word,
    output logic                     dac_data_in_updated_stb,
    output logic                     initdone
);

    dac_nano_pkg::upd_state_t state;
    dac_nano_pkg::dac_word_t  stream_word;
    logic                     bus_pend;     // bus write not yet sent
    logic                     src_stream;   // word in flight came from the stream
    logic                     start_bus;
    logic                     start_gain;

    //////////////////////////////
    // request selection

    // the current bus write counts too, register already holds it
    assign start_bus  = dac_src.avmm_mode && (bus_pend || dac_src.bus_write);
    assign start_gain = !dac_src.avmm_mode && gain_pend.pending;
    assign gain_taken = (state == dac_nano_pkg::UPD_IDLE) && start_gain;

    always_comb begin
        stream_word = dac_src.dac_reg;     // keeps the mode bits
        stream_word[dac_nano_pkg::GAIN_LSB +: $bits(dac_nano_pkg::gain_t)] = gain_pend.gain;
        stream_word[dac_nano_pkg::GAIN_LSB-1:0] = '0;
    end

    //////////////////////////////
    // transfer sequencing

    always_ff @(posedge clk_ifc) begin
        if (sreset) begin
            state                   <= dac_nano_pkg::UPD_RESET_SEND;
            spi_req                 <= 1'b0;
            spi_word                <= dac_nano_pkg::DAC_DEFAULT;
            bus_pend                <= 1'b0;
            src_stream              <= 1'b0;
            dac_data_in_updated_stb <= 1'b0;
            initdone                <= 1'b0;
        end else begin
            dac_data_in_updated_stb <= 1'b0;

            if (dac_src.bus_write) begin
                bus_pend <= 1'b1;   // coalesced while busy
            end

            case (state)
                dac_nano_pkg::UPD_RESET_SEND: begin
                    spi_req    <= 1'b1;
                    spi_word   <= dac_nano_pkg::DAC_DEFAULT;
                    src_stream <= 1'b0;
                    state      <= dac_nano_pkg::UPD_REQ;
                end
                dac_nano_pkg::UPD_IDLE: begin
                    if (start_bus) begin
                        spi_req    <= 1'b1;
                        spi_word   <= dac_src.dac_reg;
                        src_stream <= 1'b0;
                        bus_pend   <= 1'b0;
                        state      <= dac_nano_pkg::UPD_REQ;
                    end else if (start_gain) begin
                        spi_req    <= 1'b1;
                        spi_word   <= stream_word;
                        src_stream <= 1'b1;
                        state      <= dac_nano_pkg::UPD_REQ;
                    end
                end
                dac_nano_pkg::UPD_REQ: begin
                    if (spi_ack) begin
                        spi_req <= 1'b0;
                        state   <= dac_nano_pkg::UPD_RELEASE;
                    end
                end
                default: begin      // UPD_RELEASE, done at ack fall
                    if (!spi_ack) begin
                        initdone                <= 1'b1;
                        dac_data_in_updated_stb <= src_stream;
                        state                   <= dac_nano_pkg::UPD_IDLE;
                    end
                end
            endcase
        end
    end

    //////////////////////////////
    // checks

    a_word_stable: assert property (@(posedge clk_ifc) disable iff (sreset)
        spi_req && $past(spi_req) |-> $stable(spi_word));

endmodule

// File: rtl/dac_gain_in.sv
//////////////////////////////
// streamed gain capture, one pending slot
//////////////////////////////

`timescale 1ns/1ps

module dac_gain_in (
    input  logic                     clk_ifc,
    input  logic                     sreset,
    input  dac_nano_pkg::gain_t      dac_data_in,
    input  logic                     dac_data_in_valid_stb,
    input  logic                     gain_taken,
    output dac_nano_pkg::gain_pend_t gain_pend
);

    // a strobe always wins over a take in the same cycle,
    // so the newest gain is never dropped

    always_ff @(posedge clk_ifc) begin
        if (sreset) begin
            gain_pend.pending <= 1'b0;
            gain_pend.gain    <= '0;
        end else begin
            if (dac_data_in_valid_stb) begin
                gain_pend.pending <= 1'b1;
                gain_pend.gain    <= dac_data_in;   // latest wins
            end else if (gain_taken) begin
                gain_pend.pending <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // checks

    // controller only takes a gain that is held
    a_take_pending: assert property (@(posedge clk_ifc) disable iff (sreset)
        gain_taken |-> gain_pend.pending);

endmodule

// File: rtl/dac_avmm_regs.sv
//////////////////////////////
// Avalon-MM slave with the DAC register map
//////////////////////////////

`timescale 1ns/1ps

module dac_avmm_regs (
    input  logic                    clk_ifc,
    input  logic                    sreset,
    input  dac_nano_pkg::avmm_req_t avmm_req,
    input  logic                    en_avmm_ctrl,
    output dac_nano_pkg::avmm_rsp_t avmm_rsp,
    output dac_nano_pkg::dac_src_t  dac_src
);

    dac_nano_pkg::avmm_addr_t word_addr;
    dac_nano_pkg::avmm_data_t rd_data;
    dac_nano_pkg::avmm_data_t dac_reg;    // full bus word as written
    logic                     en_mirror;
    logic                     addr_err;
    logic                     rd_acc;
    logic                     wr_acc;
    logic                     dac_wr;
    logic                     bus_write_q;

    //////////////////////////////
    // address decode

    assign word_addr = avmm_req.address >> 2;
    assign addr_err  = word_addr >= dac_nano_pkg::TOTAL_REGS;

    // no transfer is taken while the slave stalls
    assign rd_acc = avmm_req.read && !avmm_rsp.waitrequest;
    assign wr_acc = avmm_req.write && !avmm_rsp.waitrequest;

    // DAC register only writable in bus mode
    assign dac_wr = wr_acc && (word_addr == dac_nano_pkg::REG_DAC) && en_mirror;

    always_comb begin
        case (word_addr)
            dac_nano_pkg::REG_VERSION_ID: begin
                rd_data = {dac_nano_pkg::MODULE_VERSION, dac_nano_pkg::MODULE_ID};
            end
            dac_nano_pkg::REG_NUM_REGS: begin
                rd_data = {24'd0, dac_nano_pkg::TOTAL_REGS};
            end
            dac_nano_pkg::REG_DAC: begin
                rd_data = dac_reg;
            end
            dac_nano_pkg::REG_EN_AVMM_CTRL: begin
                rd_data = {31'd0, en_mirror};
            end
            default: begin
                rd_data = '0;   // undefined, answered with error
            end
        endcase
    end

    //////////////////////////////
    // registers and bus response

    always_ff @(posedge clk_ifc) begin
        if (sreset) begin
            avmm_rsp.waitrequest   <= 1'b1;
            avmm_rsp.readdatavalid <= 1'b0;
            avmm_rsp.writedone     <= 1'b0;
            avmm_rsp.response      <= dac_nano_pkg::RESP_OKAY;
            avmm_rsp.readdata      <= '0;
            dac_reg                <= {16'd0, dac_nano_pkg::DAC_DEFAULT};
            en_mirror              <= 1'b0;
            bus_write_q            <= 1'b0;
        end else begin
            avmm_rsp.waitrequest   <= 1'b0;
            avmm_rsp.readdatavalid <= rd_acc;
            avmm_rsp.writedone     <= wr_acc;
            en_mirror              <= en_avmm_ctrl;
            bus_write_q            <= dac_wr;

            if (rd_acc || wr_acc) begin
                avmm_rsp.response <= addr_err ? dac_nano_pkg::RESP_SLAVE_ERROR
                                              : dac_nano_pkg::RESP_OKAY;
            end

            if (rd_acc) begin
                avmm_rsp.readdata <= rd_data;
            end

            // other defined registers are read only, write ignored
            if (dac_wr) begin
                dac_reg <= avmm_req.writedata;
            end
        end
    end

    assign dac_src = '{
        dac_reg:   dac_reg[15:0],
        bus_write: bus_write_q,
        avmm_mode: en_mirror
    };

    //////////////////////////////
    // checks

    // master never issues both commands in one cycle
    a_no_rd_wr: assert property (@(posedge clk_ifc) disable iff (sreset)
        !(avmm_req.read && avmm_req.write));

endmodule

// File: rtl/dac_nano_pkg.sv
//////////////////////////////
// shared widths, register map constants, bus and internal structs, FSM states
//////////////////////////////

package dac_nano_pkg;

    //////////////////////////////
    // vector types

    typedef logic [15:0] dac_word_t;   // one DAC shift word
    typedef logic [7:0]  gain_t;       // streamed gain value
    typedef logic [7:0]  avmm_addr_t;  // byte address
    typedef logic [31:0] avmm_data_t;

    //////////////////////////////
    // register map

    localparam avmm_addr_t REG_VERSION_ID   = 8'd0;
    localparam avmm_addr_t REG_NUM_REGS     = 8'd1;
    localparam avmm_addr_t REG_DAC          = 8'd2;
    localparam avmm_addr_t REG_EN_AVMM_CTRL = 8'd3;
    localparam avmm_addr_t TOTAL_REGS       = 8'd4;

    localparam logic [15:0] MODULE_ID      = 16'h0d5a;
    localparam logic [15:0] MODULE_VERSION = 16'h0001;

    // normal mode, mid scale
    localparam dac_word_t DAC_DEFAULT = 16'h2000;

    // mode 15:14, data 13:6, low bits unused by the DAC
    localparam int GAIN_LSB = 6;

    localparam logic [1:0] RESP_OKAY        = 2'b00;
    localparam logic [1:0] RESP_SLAVE_ERROR = 2'b10;

    //////////////////////////////
    // structs and states

    typedef struct packed {
        logic       read;
        logic       write;
        avmm_addr_t address;
        avmm_data_t writedata;
    } avmm_req_t;

    typedef struct packed {
        logic       waitrequest;
        logic       readdatavalid;
        logic       writedone;
        logic [1:0] response;
        avmm_data_t readdata;
    } avmm_rsp_t;

    typedef struct packed {
        dac_word_t dac_reg;
        logic      bus_write;  // one cycle, DAC register was written
        logic      avmm_mode;
    } dac_src_t;

    typedef struct packed {
        logic  pending;
        gain_t gain;
    } gain_pend_t;

    typedef enum logic [1:0] {UPD_RESET_SEND, UPD_IDLE, UPD_REQ, UPD_RELEASE} upd_state_t;

    typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_ACK} spi_state_t;

endpackage
